// ==== cache_pkg.sv ====
// ----------------------------------------
// Read cache shared definitions
// Widths, address split, line types, FSM states
// ----------------------------------------

package cache_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    localparam int DATA_W  = 32;              // Cached word
    localparam int TAG_W   = 3;               // Upper address bits
    localparam int INDEX_W = 5;               // Lower address bits
    localparam int ADDR_W  = TAG_W + INDEX_W; // Word address
    localparam int N_LINES = 1 << INDEX_W;    // Lines per way

    // ----------------------------------------
    // Vector types
    // ----------------------------------------

    typedef logic [DATA_W-1:0]  data_t;  // One word
    typedef logic [TAG_W-1:0]   tag_t;   // Line tag
    typedef logic [INDEX_W-1:0] index_t; // Line index
    typedef logic [ADDR_W-1:0]  addr_t;  // Tag on top, index below

    // ----------------------------------------
    // Line types
    // ----------------------------------------

    // Metadata entry, one per line
    typedef struct packed {
        logic valid; // Line holds a word
        tag_t tag;   // Tag of that word
    } meta_t;

    // Request as seen by each way
    // Field order follows addr_t so a plain cast splits the address
    typedef struct packed {
        tag_t   tag;   // Compared against metadata
        index_t index; // Selects the line
    } line_req_t;

    // ----------------------------------------
    // Controller states
    // ----------------------------------------

    typedef enum logic [1:0] {
        CLEAR, // Sweep invalidating all lines
        IDLE,  // Accept reads and flushes
        FETCH, // Wait for backing memory
        FILL   // Write fetched word into victim way
    } ctrl_state_t;

endpackage

// ==== cache_mem.sv ====
// ----------------------------------------
// Cache storage array
// Clocked write, asynchronous read, no reset
// ----------------------------------------

module cache_mem #(
    parameter int DATA_W = cache_pkg::DATA_W // Entry width
) (
    input  logic              i_clock, // Clock
    input  logic              i_we,    // Write strobe
    input  cache_pkg::index_t i_addr,  // Entry select
    input  logic [DATA_W-1:0] i_wdata, // Write data
    output logic [DATA_W-1:0] o_rdata  // Read data
);

    // One entry per line index
    logic [DATA_W-1:0] mem [cache_pkg::N_LINES];

    // Write port
    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata; // Same address as the read port
        end
    end

    // Read port, combinational so tag compare fits in the request cycle
    assign o_rdata = mem[i_addr];

endmodule

// ==== cache_set.sv ====
// ----------------------------------------
// Read cache way
// Data and metadata arrays, tag compare, fill and clear
// ----------------------------------------

module cache_set (
    input  logic                 i_clock,     // Clock
    input  logic                 i_we,        // Fill strobe
    input  logic                 i_cl,        // Clear strobe
    input  cache_pkg::line_req_t i_req,       // Index and tag
    input  cache_pkg::data_t     i_wdata,     // Fill word
    output cache_pkg::data_t     o_rdata,     // Word at the index
    output logic                 o_hit,       // Tag match on a valid line
    output logic                 o_valid_line // Valid bit at the index
);

    cache_pkg::data_t md_rdata; // Data array read
    cache_pkg::data_t md_wdata; // Data array write
    logic             md_we;    // Data array strobe
    cache_pkg::meta_t mm_rdata; // Metadata read
    cache_pkg::meta_t mm_wdata; // Metadata write
    logic             mm_we;    // Metadata strobe

    // ----------------------------------------
    // Data array control
    // ----------------------------------------

    assign md_we    = i_we & ~i_cl; // Clear leaves data alone
    assign md_wdata = i_wdata;
    assign o_rdata  = md_rdata;

    // ----------------------------------------
    // Metadata control
    // ----------------------------------------

    // Both fill and clear rewrite the entry
    assign mm_we = i_we | i_cl;

    always_comb begin
        mm_wdata.valid = 1'b1;      // Fill marks the line valid
        mm_wdata.tag   = i_req.tag; // with the request tag
        if (i_cl) begin
            mm_wdata.valid = 1'b0;                // Invalid entry
            mm_wdata.tag   = cache_pkg::tag_t'(0); // Zero tag
        end
    end

    // Hit is masked while the line is being rewritten
    assign o_hit = mm_rdata.valid & (mm_rdata.tag == i_req.tag) & ~i_we & ~i_cl;

    assign o_valid_line = mm_rdata.valid; // Lets the tracker pick an empty way

    // ----------------------------------------
    // Arrays
    // ----------------------------------------

    cache_mem #(
        .DATA_W (cache_pkg::DATA_W)
    ) u_data_mem (
        .i_clock (i_clock),
        .i_we    (md_we),
        .i_addr  (i_req.index),
        .i_wdata (md_wdata),
        .o_rdata (md_rdata)
    );

    cache_mem #(
        .DATA_W ($bits(cache_pkg::meta_t))
    ) u_meta_mem (
        .i_clock (i_clock),
        .i_we    (mm_we),
        .i_addr  (i_req.index),
        .i_wdata (mm_wdata),
        .o_rdata (mm_rdata)
    );

endmodule

// ==== cache_lru.sv ====
// ----------------------------------------
// Recency tracker for a two-way cache
// One recency bit per index picks the victim way
// ----------------------------------------

module cache_lru (
    input  logic              i_clock,  // Clock
    input  logic              i_arst_n, // Async reset, active low
    input  cache_pkg::index_t i_index,  // Line being looked at
    input  logic              i_touch,  // Update recency
    input  logic              i_way,    // Way just used
    input  logic              i_valid0, // Way 0 line valid
    input  logic              i_valid1, // Way 1 line valid
    output logic              o_victim  // Way to replace
);

    // Way used last at each index
    logic [cache_pkg::N_LINES-1:0] recent;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            recent <= '0;
        end else if (i_touch) begin
            recent[i_index] <= i_way; // Hit or fill
        end
    end

    // Empty ways first, then the older way
    always_comb begin
        if (!i_valid0) begin
            o_victim = 1'b0;
        end else if (!i_valid1) begin
            o_victim = 1'b1;
        end else begin
            o_victim = ~recent[i_index];
        end
    end

endmodule

// ==== cache_ctrl.sv ====
// ----------------------------------------
// Read cache controller
// Clear sweep, hit response, miss fetch and fill
// ----------------------------------------

module cache_ctrl (
    input  logic              i_clock,        // Clock
    input  logic              i_arst_n,       // Async reset, active low
    input  logic              i_rd,           // Read request
    input  logic              i_flush,        // Flush request
    input  logic              i_hit0,         // Way 0 hit
    input  logic              i_hit1,         // Way 1 hit
    input  logic              i_victim,       // Way to replace on a miss
    input  logic              i_mem_ack,      // Backing memory answer
    output logic              o_busy,         // Requests ignored
    output logic              o_mem_req,      // Fetch pulse
    output logic              o_we0,          // Fill way 0
    output logic              o_we1,          // Fill way 1
    output logic              o_cl,           // Clear both ways
    output cache_pkg::index_t o_clr_index,    // Line being cleared
    output logic              o_touch,        // Recency update
    output logic              o_way,          // Way used
    output logic              o_resp,         // Response next cycle
    output logic              o_resp_sel_mem, // Respond with fetched word
    output logic              o_hold_addr     // Keep the missed address
);

    cache_pkg::ctrl_state_t state;     // Current state
    cache_pkg::ctrl_state_t state_nxt; // Next state
    cache_pkg::index_t      clr_cnt;   // Sweep position
    logic                   victim_q;  // Way chosen at the miss
    logic                   mem_req_q; // Registered fetch pulse
    logic                   hit;       // Either way hit
    logic                   idle;      // Accepting requests
    logic                   rd_go;     // Read accepted
    logic                   hit_go;    // Accepted read hits
    logic                   miss_go;   // Accepted read misses
    logic                   filling;   // Victim write cycle

    // ----------------------------------------
    // Acceptance
    // ----------------------------------------

    assign hit     = i_hit0 | i_hit1;
    assign idle    = (state == cache_pkg::IDLE);
    assign rd_go   = idle & i_rd & ~i_flush; // Flush wins
    assign hit_go  = rd_go & hit;
    assign miss_go = rd_go & ~hit;
    assign filling = (state == cache_pkg::FILL);

    // ----------------------------------------
    // State machine
    // ----------------------------------------

    always_comb begin
        state_nxt = state;
        unique case (state)
            cache_pkg::CLEAR: begin
                if (clr_cnt == cache_pkg::index_t'(cache_pkg::N_LINES - 1)) begin
                    state_nxt = cache_pkg::IDLE; // Last line cleared
                end
            end
            cache_pkg::IDLE: begin
                if (idle & i_flush) begin
                    state_nxt = cache_pkg::CLEAR;
                end else if (miss_go) begin
                    state_nxt = cache_pkg::FETCH;
                end
            end
            cache_pkg::FETCH: begin
                if (i_mem_ack) begin
                    state_nxt = cache_pkg::FILL; // No timeout
                end
            end
            cache_pkg::FILL: begin
                state_nxt = cache_pkg::IDLE; // Single write cycle
            end
            default: begin
                state_nxt = cache_pkg::CLEAR;
            end
        endcase
    end

    // Sweep starts right out of reset
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= cache_pkg::CLEAR;
            clr_cnt   <= '0;
            victim_q  <= 1'b0;
            mem_req_q <= 1'b0;
        end else begin
            state     <= state_nxt;
            mem_req_q <= miss_go;                 // First FETCH cycle
            if (state == cache_pkg::CLEAR) begin
                clr_cnt <= clr_cnt + 1'b1;        // Wraps to 0 at the end
            end else begin
                clr_cnt <= '0;
            end
            if (miss_go) begin
                victim_q <= i_victim;             // Valid bits of the missed index
            end
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------

    assign o_busy         = ~idle;
    assign o_mem_req      = mem_req_q;
    assign o_cl           = (state == cache_pkg::CLEAR);
    assign o_clr_index    = clr_cnt;
    assign o_we0          = filling & ~victim_q;
    assign o_we1          = filling & victim_q;
    assign o_touch        = hit_go | filling;
    assign o_way          = filling ? victim_q : i_hit1; // Filled or hitting way
    assign o_resp         = hit_go | filling;
    assign o_resp_sel_mem = filling;
    assign o_hold_addr    = (state == cache_pkg::FETCH) | filling;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    a_mem_req_pulse: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        o_mem_req |=> !o_mem_req
    ) else $error("o_mem_req held longer than one cycle");

    // A tag lives in at most one way
    a_one_hit: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        (idle && i_rd) |-> !(i_hit0 && i_hit1)
    ) else $error("both ways hit the same address");

    a_ack_in_fetch: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        i_mem_ack |-> (state == cache_pkg::FETCH)
    ) else $error("i_mem_ack outside FETCH");

endmodule

// ==== read_cache.sv ====
// ----------------------------------------
// Two-way set-associative read cache
// Ways, recency tracker, controller, response register
// ----------------------------------------

module read_cache (
    input  logic              i_clock,    // Clock
    input  logic              i_arst_n,   // Async reset, active low
    input  logic              i_rd,       // Read request
    input  cache_pkg::addr_t  i_addr,     // Read address
    input  logic              i_flush,    // Invalidate everything
    output logic              o_busy,     // Requests ignored
    output logic              o_valid,    // Read data pulse
    output cache_pkg::data_t  o_rdata,    // Read data
    output logic              o_mem_req,  // Fetch pulse
    output cache_pkg::addr_t  o_mem_addr, // Fetch address
    input  logic              i_mem_ack,  // Fetch answer
    input  cache_pkg::data_t  i_mem_rdata // Fetched word
);

    cache_pkg::addr_t     addr_q;       // Held request address
    cache_pkg::data_t     mem_q;        // Fetched word
    cache_pkg::line_req_t live_req;     // Incoming or held request
    cache_pkg::line_req_t req;          // What the ways see
    cache_pkg::index_t    clr_index;    // Sweep position
    cache_pkg::data_t     rdata0;       // Way 0 word
    cache_pkg::data_t     rdata1;       // Way 1 word
    logic                 we0;          // Way 0 fill
    logic                 we1;          // Way 1 fill
    logic                 cl;           // Clear strobe
    logic                 hit0;         // Way 0 hit
    logic                 hit1;         // Way 1 hit
    logic                 valid0;       // Way 0 line valid
    logic                 valid1;       // Way 1 line valid
    logic                 victim;       // Replacement way
    logic                 touch;        // Recency update
    logic                 way;          // Way used
    logic                 resp;         // Respond next cycle
    logic                 resp_sel_mem; // Response from memory
    logic                 hold_addr;    // Miss in progress

    // ----------------------------------------
    // Address path
    // ----------------------------------------

    // Follows the input until a miss freezes it
    always_ff @(posedge i_clock) begin
        if (!hold_addr) begin
            addr_q <= i_addr;
        end
    end

    assign live_req = cache_pkg::line_req_t'(hold_addr ? addr_q : i_addr);

    always_comb begin
        req = live_req;
        if (cl) begin
            req.index = clr_index; // Sweep overrides the request index
        end
    end

    assign o_mem_addr = addr_q;

    // Fill word, stable through FILL
    always_ff @(posedge i_clock) begin
        if (i_mem_ack) begin
            mem_q <= i_mem_rdata;
        end
    end

    // ----------------------------------------
    // Ways and tracker
    // ----------------------------------------

    cache_set u_way0 (
        .i_clock      (i_clock),
        .i_we         (we0),
        .i_cl         (cl),
        .i_req        (req),
        .i_wdata      (mem_q),
        .o_rdata      (rdata0),
        .o_hit        (hit0),
        .o_valid_line (valid0)
    );

    cache_set u_way1 (
        .i_clock      (i_clock),
        .i_we         (we1),
        .i_cl         (cl),
        .i_req        (req),
        .i_wdata      (mem_q),
        .o_rdata      (rdata1),
        .o_hit        (hit1),
        .o_valid_line (valid1)
    );

    cache_lru u_lru (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_index  (req.index),
        .i_touch  (touch),
        .i_way    (way),
        .i_valid0 (valid0),
        .i_valid1 (valid1),
        .o_victim (victim)
    );

    cache_ctrl u_ctrl (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_rd           (i_rd),
        .i_flush        (i_flush),
        .i_hit0         (hit0),
        .i_hit1         (hit1),
        .i_victim       (victim),
        .i_mem_ack      (i_mem_ack),
        .o_busy         (o_busy),
        .o_mem_req      (o_mem_req),
        .o_we0          (we0),
        .o_we1          (we1),
        .o_cl           (cl),
        .o_clr_index    (clr_index),
        .o_touch        (touch),
        .o_way          (way),
        .o_resp         (resp),
        .o_resp_sel_mem (resp_sel_mem),
        .o_hold_addr    (hold_addr)
    );

    // ----------------------------------------
    // Response register
    // ----------------------------------------

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= resp; // One cycle after the accepting edge
        end
    end

    always_ff @(posedge i_clock) begin
        if (resp) begin
            o_rdata <= resp_sel_mem ? mem_q : (hit1 ? rdata1 : rdata0);
        end
    end

endmodule

// ==== tb_mem_model.sv ====
// ----------------------------------------
// Backing memory model for the read cache
// Random word table, ack after 1 to 4 cycles
// ----------------------------------------

module tb_mem_model (
    input  logic             i_clock,     // Clock
    input  logic             i_mem_req,   // Fetch pulse from the cache
    input  cache_pkg::addr_t i_mem_addr,  // Fetch address
    output logic             o_mem_ack,   // One-cycle answer
    output cache_pkg::data_t o_mem_rdata, // Word with the ack
    output int unsigned      o_req_count  // Requests seen so far
);

    cache_pkg::data_t word_mem [1 << cache_pkg::ADDR_W]; // One word per address
    cache_pkg::addr_t addr_q;                            // Address being served
    int unsigned      delay;                             // Cycles before the ack

    initial begin
        o_mem_ack   = 1'b0;
        o_mem_rdata = '0;
        o_req_count = 0;
        #1; // Seed is set at time 0
        for (int i = 0; i < (1 << cache_pkg::ADDR_W); i++) begin
            word_mem[i] = $urandom;
        end
    end

    // Sample on the falling edge, away from the DUT's register updates
    always begin
        @(negedge i_clock);
        if (i_mem_req === 1'b1) begin
            addr_q      = i_mem_addr;
            o_req_count = o_req_count + 1;
            delay       = 1 + ($urandom % 4);
            repeat (delay) @(posedge i_clock);
            #2;
            o_mem_ack   = 1'b1;
            o_mem_rdata = word_mem[addr_q];
            @(posedge i_clock);
            #2;
            o_mem_ack   = 1'b0; // Single-cycle ack
            o_mem_rdata = '0;
        end
    end

endmodule

// ==== tb_read_cache.sv ====
// ----------------------------------------
// Read cache testbench
// Table of reads and flushes against a recency model
// ----------------------------------------

module tb_read_cache;

    localparam int TIMEOUT_CYC = 200; // Limit for every wait

    // One stimulus row
    typedef struct packed {
        logic [2:0]       test;    // Behavior group
        logic             flush;   // Flush instead of read
        cache_pkg::addr_t addr;    // Read address
        logic             exp_hit; // Filled in by the model
    } stim_t;

    logic             i_clock;
    logic             i_arst_n;
    logic             i_rd;
    cache_pkg::addr_t i_addr;
    logic             i_flush;
    logic             o_busy;
    logic             o_valid;
    cache_pkg::data_t o_rdata;
    logic             o_mem_req;
    cache_pkg::addr_t o_mem_addr;
    logic             i_mem_ack;
    cache_pkg::data_t i_mem_rdata;
    int unsigned      req_count; // Requests seen by the memory

    // ----------------------------------------
    // Reference state
    // ----------------------------------------

    stim_t           rows [$];
    logic            model_valid  [2][cache_pkg::N_LINES];
    cache_pkg::tag_t model_tag    [2][cache_pkg::N_LINES];
    logic            model_recent [cache_pkg::N_LINES]; // Way used last
    int unsigned     exp_count; // Expected memory requests
    int              err_cnt;
    int              n_ok;
    int              n_bad;
    logic            aborted;   // A wait ran out

    initial i_clock = 1'b0;
    always #20 i_clock = ~i_clock; // Period 40

    read_cache u_dut (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_rd        (i_rd),
        .i_addr      (i_addr),
        .i_flush     (i_flush),
        .o_busy      (o_busy),
        .o_valid     (o_valid),
        .o_rdata     (o_rdata),
        .o_mem_req   (o_mem_req),
        .o_mem_addr  (o_mem_addr),
        .i_mem_ack   (i_mem_ack),
        .i_mem_rdata (i_mem_rdata)
    );

    tb_mem_model u_mem (
        .i_clock     (i_clock),
        .i_mem_req   (o_mem_req),
        .i_mem_addr  (o_mem_addr),
        .o_mem_ack   (i_mem_ack),
        .o_mem_rdata (i_mem_rdata),
        .o_req_count (req_count)
    );

    // ----------------------------------------
    // Reporting
    // ----------------------------------------

    task automatic report_mismatch(input string sig, input cache_pkg::data_t exp_v,
                                   input cache_pkg::data_t got_v);
        $display("** Error: %s expected 0x%0h got 0x%0h at %0t", sig, exp_v, got_v, $time);
        err_cnt++;
    endtask

    task automatic report_timeout(input string what);
        cache_pkg::ctrl_state_t st;
        st = u_dut.u_ctrl.state; // Where the controller got stuck
        $display("Timeout: %s did not happen within %0d cycles, controller in %s",
                 what, TIMEOUT_CYC, st.name());
        err_cnt++;
        aborted = 1'b1;
    endtask

    function automatic string test_title(input int test);
        case (test)
            1:       return "reset and first miss";
            2:       return "repeat and back-to-back hits";
            3:       return "same index eviction";
            4:       return "flush then reread";
            default: return "random reads";
        endcase
    endfunction

    // ----------------------------------------
    // Waits, sampled 2 units after the edge
    // ----------------------------------------

    task automatic wait_idle();
        int n;
        n = 0;
        while (o_busy !== 1'b0 && n < TIMEOUT_CYC) begin
            @(posedge i_clock);
            #2;
            n++;
        end
        if (o_busy !== 1'b0) report_timeout("o_busy low");
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (o_valid !== 1'b1 && n < TIMEOUT_CYC) begin
            @(posedge i_clock);
            #2;
            n++;
        end
        if (o_valid !== 1'b1) report_timeout("o_valid pulse after a miss");
    endtask

    // ----------------------------------------
    // Model of tags, valid and recent bits
    // ----------------------------------------

    task automatic predict_read(input cache_pkg::addr_t addr, output logic hit);
        cache_pkg::tag_t   tg;
        cache_pkg::index_t idx;
        logic              way;
        tg  = addr[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W];
        idx = addr[cache_pkg::INDEX_W-1:0];
        hit = 1'b1;
        if (model_valid[0][idx] && model_tag[0][idx] == tg) begin
            way = 1'b0;
        end else if (model_valid[1][idx] && model_tag[1][idx] == tg) begin
            way = 1'b1;
        end else begin
            hit = 1'b0;
            if (!model_valid[0][idx]) way = 1'b0;      // Empty way first
            else if (!model_valid[1][idx]) way = 1'b1;
            else way = ~model_recent[idx];              // Older way
            model_valid[way][idx] = 1'b1;
            model_tag[way][idx]   = tg;
        end
        model_recent[idx] = way; // Hit or fill both count as use
    endtask

    task automatic add_row(input logic [2:0] test, input logic flush,
                           input cache_pkg::addr_t addr);
        stim_t row;
        row.test    = test;
        row.flush   = flush;
        row.addr    = addr;
        row.exp_hit = 1'b0;
        rows.push_back(row);
    endtask

    task automatic build_rows();
        logic [3:0] sub;
        add_row(3'd1, 1'b0, 8'h25); // Cold miss
        add_row(3'd2, 1'b0, 8'h25); // Same word again
        add_row(3'd2, 1'b0, 8'h10);
        add_row(3'd2, 1'b0, 8'h11);
        add_row(3'd2, 1'b0, 8'h12);
        add_row(3'd2, 1'b0, 8'h10); // Back-to-back hits from here
        add_row(3'd2, 1'b0, 8'h11);
        add_row(3'd2, 1'b0, 8'h12);
        add_row(3'd2, 1'b0, 8'h25);
        add_row(3'd3, 1'b0, 8'h03); // Index 3, tag 0
        add_row(3'd3, 1'b0, 8'h23); // Index 3, tag 1
        add_row(3'd3, 1'b0, 8'h03);
        add_row(3'd3, 1'b0, 8'h23);
        add_row(3'd3, 1'b0, 8'h43); // Third tag evicts the older way
        add_row(3'd3, 1'b0, 8'h23); // Kept
        add_row(3'd3, 1'b0, 8'h03); // Evicted
        add_row(3'd4, 1'b1, 8'h00);
        add_row(3'd4, 1'b0, 8'h25);
        add_row(3'd4, 1'b0, 8'h10);
        add_row(3'd4, 1'b0, 8'h11);
        add_row(3'd4, 1'b0, 8'h12);
        add_row(3'd4, 1'b0, 8'h23);
        add_row(3'd4, 1'b0, 8'h03);
        // Tags 0..3 on indexes 0..3, plenty of conflicts
        for (int k = 0; k < 200; k++) begin
            sub = 4'($urandom % 16);
            add_row(3'd5, 1'b0, {1'b0, sub[3:2], 3'b000, sub[1:0]});
        end
    endtask

    task automatic predict_rows();
        logic hit;
        for (int i = 0; i < cache_pkg::N_LINES; i++) begin
            model_valid[0][i] = 1'b0;
            model_valid[1][i] = 1'b0;
            model_tag[0][i]   = '0;
            model_tag[1][i]   = '0;
            model_recent[i]   = 1'b0; // Cleared by reset only
        end
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].flush) begin
                for (int j = 0; j < cache_pkg::N_LINES; j++) begin
                    model_valid[0][j] = 1'b0;
                    model_valid[1][j] = 1'b0;
                end
            end else begin
                predict_read(rows[i].addr, hit);
                rows[i].exp_hit = hit;
            end
        end
    endtask

    // ----------------------------------------
    // Row drivers
    // ----------------------------------------

    task automatic apply_read(input stim_t row);
        cache_pkg::data_t exp_word;
        exp_word = u_mem.word_mem[row.addr];
        wait_idle();
        if (aborted) return;
        if (req_count !== exp_count) report_mismatch("request count", exp_count, req_count);
        i_rd   = 1'b1;
        i_addr = row.addr;
        @(posedge i_clock); // Accepting edge
        #2;
        i_rd = 1'b0;
        if (row.exp_hit) begin
            if (o_valid !== 1'b1) report_mismatch("o_valid", 1, o_valid);
            if (o_rdata !== exp_word) report_mismatch("o_rdata", exp_word, o_rdata);
            if (o_mem_req !== 1'b0) report_mismatch("o_mem_req", 0, o_mem_req);
        end else begin
            exp_count++;
            if (o_valid !== 1'b0) report_mismatch("o_valid", 0, o_valid);
            if (o_busy !== 1'b1) report_mismatch("o_busy", 1, o_busy);
            if (o_mem_req !== 1'b1) report_mismatch("o_mem_req", 1, o_mem_req);
            if (o_mem_addr !== row.addr) report_mismatch("o_mem_addr", row.addr, o_mem_addr);
            wait_valid();
            if (aborted) return;
            if (o_rdata !== exp_word) report_mismatch("o_rdata", exp_word, o_rdata);
            if (o_busy !== 1'b0) report_mismatch("o_busy", 0, o_busy);
            if (req_count !== exp_count) report_mismatch("request count", exp_count, req_count);
        end
    endtask

    task automatic apply_flush();
        int n;
        wait_idle();
        if (aborted) return;
        i_flush = 1'b1;
        @(posedge i_clock);
        #2;
        i_flush = 1'b0;
        n = 0;
        while (o_busy === 1'b1 && n < TIMEOUT_CYC) begin
            n++;
            @(posedge i_clock);
            #2;
        end
        if (o_busy !== 1'b0) begin
            report_timeout("end of flush sweep");
        end else if (n != cache_pkg::N_LINES) begin
            report_mismatch("o_busy cycles", cache_pkg::N_LINES, n); // One line per cycle
        end
    endtask

    task automatic finish_test(input int test, input int base);
        if (!aborted) begin
            @(posedge i_clock); // Late requests show up by now
            #2;
            wait_idle();
            if (req_count !== exp_count) report_mismatch("request count", exp_count, req_count);
        end
        if (err_cnt == base) begin
            n_ok++;
            $display("behavior %0d, %s: ok", test, test_title(test));
        end else begin
            n_bad++;
            $display("behavior %0d, %s: %0d errors", test, test_title(test), err_cnt - base);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        int cur;
        int base;
        void'($urandom(39));
        i_arst_n  = 1'b0;
        i_rd      = 1'b0;
        i_addr    = '0;
        i_flush   = 1'b0;
        err_cnt   = 0;
        n_ok      = 0;
        n_bad     = 0;
        exp_count = 0;
        aborted   = 1'b0;
        build_rows();
        predict_rows();
        cur  = rows[0].test;
        base = 0;
        repeat (2) @(posedge i_clock);
        #2;
        if (o_busy !== 1'b1) report_mismatch("o_busy", 1, o_busy); // Sweep pending
        if (o_valid !== 1'b0) report_mismatch("o_valid", 0, o_valid);
        if (o_mem_req !== 1'b0) report_mismatch("o_mem_req", 0, o_mem_req);
        i_arst_n = 1'b1;
        wait_idle();
        for (int i = 0; i < rows.size(); i++) begin
            if (aborted) break;
            if (rows[i].test != cur) begin
                finish_test(cur, base);
                cur  = rows[i].test;
                base = err_cnt;
            end
            if (rows[i].flush) apply_flush();
            else apply_read(rows[i]);
        end
        finish_test(cur, base);
        $display("behaviors: %0d ok, %0d with errors, %0d errors in all", n_ok, n_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
cache_pkg.sv
cache_mem.sv
cache_set.sv
cache_lru.sv
cache_ctrl.sv
read_cache.sv
tb_mem_model.sv
tb_read_cache.sv

// ==== Bender.yml ====
package:
  name: read_cache

sources:
  - files:
      - cache_pkg.sv
      - cache_mem.sv
      - cache_set.sv
      - cache_lru.sv
      - cache_ctrl.sv
      - read_cache.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_read_cache.sv
